/* project.f */
verilog/shift_pkg.sv
verilog/operand_resolver.sv
verilog/barrel_shifter.sv
verilog/shift_stage_reg.sv
verilog/shift_stage_top.sv
sim/tb_clock_gen.sv
sim/shift_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the shift stage testbench with Verilator and runs it.
# Exit status is zero only when the run reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
        -f project.f --top-module shift_stage_tb -o shift_stage_sim
if [ $? -ne 0 ]; then
        echo "Verilator build failed."
        exit 1
fi

output=$(./obj_dir/shift_stage_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status."
        exit 1
fi

if echo "$output" | grep -qx '>>> PASS'; then
        exit 0
fi
echo "Pass message not found in simulation output."
exit 1

/* sim/shift_stage_tb.sv */
`timescale 1ns/1ps

module shift_stage_tb;

// Run length.
localparam int NUM_OPS        = 2000;
localparam int RESET_CYCLES   = 8;
// One op per cycle plus five percent slack.
localparam int TIMEOUT_CYCLES = NUM_OPS + NUM_OPS / 20;
// Physical registers in use.
localparam int NUM_REGS       = 46;

logic clk;
logic reset;

// DUT inputs.
logic                            valid;
logic [shift_pkg::SRC_W-1:0]     alu_source;
logic [shift_pkg::DATA_W-1:0]    alu_source_value;
logic [shift_pkg::SRC_W-1:0]     shift_source;
logic [shift_pkg::DATA_W-1:0]    shift_source_value;
logic [shift_pkg::DATA_W-1:0]    shift_length_value;
shift_pkg::shift_op_t            shift_op;
logic                            disable_shifter;
logic [shift_pkg::REG_IDX_W-1:0] destination_index;
logic                            carry_in;
logic [shift_pkg::DATA_W-1:0]    alu_value;
logic                            alu_dav;
logic                            stall;
logic                            clear;

// DUT outputs.
logic                            out_valid;
logic [shift_pkg::DATA_W-1:0]    out_alu_source_value;
logic [shift_pkg::DATA_W-1:0]    out_shifted_value;
logic                            out_shift_carry;
logic [shift_pkg::REG_IDX_W-1:0] out_destination_index;

// Model stage register, and its next state.
logic                            m_valid;
logic [shift_pkg::DATA_W-1:0]    m_alu;
logic [shift_pkg::DATA_W-1:0]    m_shifted;
logic                            m_carry;
logic [shift_pkg::REG_IDX_W-1:0] m_dest;
logic                            n_valid;
logic [shift_pkg::DATA_W-1:0]    n_alu;
logic [shift_pkg::DATA_W-1:0]    n_shifted;
logic                            n_carry;
logic [shift_pkg::REG_IDX_W-1:0] n_dest;

integer seed;
int     cycle_count = 0;

tb_clock_gen clock_gen_inst
(
        .o_clk (clk)
);

shift_stage_top shift_stage_top_inst
(
        .i_clk                (clk),
        .i_reset              (reset),
        .i_valid              (valid),
        .i_alu_source         (alu_source),
        .i_alu_source_value   (alu_source_value),
        .i_shift_source       (shift_source),
        .i_shift_source_value (shift_source_value),
        .i_shift_length_value (shift_length_value),
        .i_shift_op           (shift_op),
        .i_disable_shifter    (disable_shifter),
        .i_destination_index  (destination_index),
        .i_carry_in           (carry_in),
        .i_alu_value          (alu_value),
        .i_alu_dav            (alu_dav),
        .i_stall              (stall),
        .i_clear              (clear),
        .o_valid              (out_valid),
        .o_alu_source_value   (out_alu_source_value),
        .o_shifted_value      (out_shifted_value),
        .o_shift_carry        (out_shift_carry),
        .o_destination_index  (out_destination_index)
);

////////////////////////////////////////////////////////////
// Random stimulus.
////////////////////////////////////////////////////////////

function automatic logic [31:0] random_word();
        return $random(seed);
endfunction

// Immediate one time in four, else a register index.
function automatic logic [shift_pkg::SRC_W-1:0] random_source();
        logic [31:0]                     pick;
        logic [31:0]                     tmp;
        logic [shift_pkg::REG_IDX_W-1:0] index;

        pick = random_word();
        if (pick[1:0] == 2'd0)
                return {1'b1, random_word()};
        // Half of register sources hit the staged destination.
        if (pick[2])
        begin
                index = m_dest;
        end
        else
        begin
                tmp   = random_word() % NUM_REGS;
                index = tmp[shift_pkg::REG_IDX_W-1:0];
        end
        return {1'b0, {(shift_pkg::DATA_W - shift_pkg::REG_IDX_W){1'b0}}, index};
endfunction

// Amount classes: zero, 1 to 31, 32, multiples of 32, above 32.
function automatic logic [31:0] random_length();
        logic [31:0] word;
        logic [31:0] pick;
        logic [31:0] tmp;

        word = random_word();
        pick = random_word();
        case (pick % 6)
        0:       tmp = 32'd0;
        1, 2:    tmp = (word[15:8] % 31) + 1;
        3:       tmp = 32'd32;
        4:       tmp = {27'd0, word[10:8], 2'd0} << 3;
        default: tmp = (word[15:8] % 223) + 33;
        endcase
        // Upper bytes are noise the stage must ignore.
        return {word[31:8], tmp[7:0]};
endfunction

function automatic shift_pkg::shift_op_t random_op();
        logic [31:0] pick;

        pick = random_word() % 5;
        case (pick)
        0:       return shift_pkg::SH_LSL;
        1:       return shift_pkg::SH_LSR;
        2:       return shift_pkg::SH_ASR;
        3:       return shift_pkg::SH_ROR;
        default: return shift_pkg::SH_RRX;
        endcase
endfunction

////////////////////////////////////////////////////////////
// Reference model.
////////////////////////////////////////////////////////////

// Immediate, then ALU forward, then the issue read.
function automatic logic [shift_pkg::DATA_W-1:0] forward_operand
(
        input logic [shift_pkg::SRC_W-1:0]  source,
        input logic [shift_pkg::DATA_W-1:0] issue_value
);
        if (source[shift_pkg::IMMED_BIT])
                return source[shift_pkg::DATA_W-1:0];
        if (alu_dav && source[shift_pkg::REG_IDX_W-1:0] == m_dest)
                return alu_value;
        return issue_value;
endfunction

// Carry on top, result below.
function automatic logic [32:0] expected_shift
(
        input logic [31:0]          s,
        input logic [7:0]           amount,
        input shift_pkg::shift_op_t op,
        input logic                 cin,
        input logic                 bypass
);
        int          k;
        int          n;
        logic [31:0] r;
        logic [31:0] out_bits;
        logic [63:0] doubled;

        k = int'(amount);
        n = int'(amount[4:0]);
        if (bypass || (k == 0 && op != shift_pkg::SH_RRX))
                return {cin, s};
        case (op)
        shift_pkg::SH_RRX:
                return {s[0], cin, s[31:1]};
        shift_pkg::SH_LSL:
        begin
                if (k > 32)
                        return 33'd0;
                if (k == 32)
                        return {s[0], 32'd0};
                out_bits = s >> (32 - k);
                return {out_bits[0], s << k};
        end
        shift_pkg::SH_LSR:
        begin
                if (k > 32)
                        return 33'd0;
                if (k == 32)
                        return {s[31], 32'd0};
                out_bits = s >> (k - 1);
                return {out_bits[0], s >> k};
        end
        shift_pkg::SH_ASR:
        begin
                if (k >= 32)
                        return {s[31], {32{s[31]}}};
                out_bits = s >> (k - 1);
                r = $signed(s) >>> k;
                return {out_bits[0], r};
        end
        shift_pkg::SH_ROR:
        begin
                // Multiple of 32 leaves the source, carry is bit 31.
                doubled = {s, s} >> n;
                r = doubled[31:0];
                return {r[31], r};
        end
        default:
                return {cin, s};
        endcase
endfunction

////////////////////////////////////////////////////////////
// Drive, model update and checks.
////////////////////////////////////////////////////////////

task automatic set_idle_inputs();
        valid              = 1'b0;
        alu_source         = '0;
        alu_source_value   = '0;
        shift_source       = '0;
        shift_source_value = '0;
        shift_length_value = '0;
        shift_op           = shift_pkg::SH_LSL;
        disable_shifter    = 1'b0;
        destination_index  = '0;
        carry_in           = 1'b0;
        alu_value          = '0;
        alu_dav            = 1'b0;
        stall              = 1'b0;
        clear              = 1'b0;
endtask

// Drives one op and works out the stage state after the next edge.
task automatic drive_random_op();
        logic [31:0] pick;
        logic [31:0] tmp;
        logic [32:0] shift_out;
        logic [31:0] shift_operand;

        pick  = random_word();
        valid = (pick[2:0] != 3'd0);
        // Clear about one in 16, stall one in 8, sometimes both.
        clear = (pick[6:3] == 4'd0);
        stall = (pick[9:7] == 3'd0);
        disable_shifter = (pick[12:10] == 3'd0);
        carry_in  = pick[13];
        alu_dav   = (pick[15:14] != 2'd0);
        alu_value = random_word();

        alu_source         = random_source();
        alu_source_value   = random_word();
        shift_source       = random_source();
        shift_source_value = random_word();
        shift_length_value = random_length();
        shift_op           = random_op();
        tmp                = random_word() % NUM_REGS;
        destination_index  = tmp[shift_pkg::REG_IDX_W-1:0];

        shift_operand = forward_operand(shift_source, shift_source_value);
        shift_out = expected_shift(shift_operand,
                                   shift_length_value[shift_pkg::AMOUNT_W-1:0],
                                   shift_op, carry_in, disable_shifter);

        // Hold everything by default.
        n_valid   = m_valid;
        n_alu     = m_alu;
        n_shifted = m_shifted;
        n_carry   = m_carry;
        n_dest    = m_dest;
        if (clear)
        begin
                n_valid = 1'b0;
        end
        else if (!stall)
        begin
                n_valid   = valid;
                n_alu     = forward_operand(alu_source, alu_source_value);
                n_shifted = shift_out[31:0];
                n_carry   = shift_out[32];
                n_dest    = destination_index;
        end
endtask

task automatic commit_model();
        m_valid   = n_valid;
        m_alu     = n_alu;
        m_shifted = n_shifted;
        m_carry   = n_carry;
        m_dest    = n_dest;
endtask

task automatic check_value
(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
);
        if (actual !== expected)
        begin
                $display("[FAIL] t=%0t %s actual=0x%08h expected=0x%08h",
                         $time, name, actual, expected);
                $display(">>> FAIL");
                $fatal(1, "output mismatch on %s", name);
        end
endtask

// Payload only means something while the stage is valid.
task automatic check_outputs();
        check_value("o_valid", 32'(out_valid), 32'(m_valid));
        check_value("o_destination_index", 32'(out_destination_index), 32'(m_dest));
        if (m_valid)
        begin
                check_value("o_alu_source_value", out_alu_source_value, m_alu);
                check_value("o_shifted_value", out_shifted_value, m_shifted);
                check_value("o_shift_carry", 32'(out_shift_carry), 32'(m_carry));
        end
endtask

////////////////////////////////////////////////////////////
// Main sequence and timeout.
////////////////////////////////////////////////////////////

initial
begin
        seed = 32'h8795;
        set_idle_inputs();
        reset = 1'b1;
        // Reset state of the stage.
        m_valid   = 1'b0;
        m_dest    = '0;
        m_alu     = '0;
        m_shifted = '0;
        m_carry   = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        check_outputs();

        for (int op_count = 0; op_count < NUM_OPS; op_count++)
        begin
                drive_random_op();
                @(posedge clk);
                #1;
                commit_model();
                check_outputs();
        end

        $display(">>> PASS");
        $finish;
end

always @(posedge clk)
begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
                $display("Timeout: the run did not finish within %0d cycles.",
                         TIMEOUT_CYCLES);
                $display(">>> FAIL");
                $fatal(1, "timeout");
        end
end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
(
        output logic o_clk
);

// Half of the 4 ns period.
localparam int HALF_PERIOD_NS = 2;

////////////////////////////////////////////////////////////
// Free running clock, first rising edge at 2 ns.
////////////////////////////////////////////////////////////

initial
begin
        o_clk = 1'b0;
        forever
                #HALF_PERIOD_NS o_clk = ~o_clk;
end

endmodule

/* verilog/barrel_shifter.sv */
`timescale 1ns/1ps

module barrel_shifter
(
        // Clock and reset, only for the opcode check.
        input  logic                            i_clk,
        input  logic                            i_reset,

        // Forwarded shift source and the amount.
        input  logic [shift_pkg::DATA_W-1:0]    i_source,
        input  logic [shift_pkg::AMOUNT_W-1:0]  i_amount,
        input  shift_pkg::shift_op_t            i_shift_op,
        input  logic                            i_carry_in,
        input  logic                            i_disable,

        // Result and carry-out.
        output logic [shift_pkg::DATA_W-1:0]    o_result,
        output logic                            o_carry
);

////////////////////////////////////////////////////////////
// Amount decode.
////////////////////////////////////////////////////////////

// Low five bits of the amount.
logic [$clog2(shift_pkg::DATA_W)-1:0] low_amount;

logic amount_zero;
logic amount_below;
logic amount_equal;

assign low_amount   = i_amount[$clog2(shift_pkg::DATA_W)-1:0];
assign amount_zero  = (i_amount == '0);
assign amount_below = (i_amount < shift_pkg::AMOUNT_W'(shift_pkg::DATA_W));
assign amount_equal = (i_amount == shift_pkg::AMOUNT_W'(shift_pkg::DATA_W));

////////////////////////////////////////////////////////////
// Raw shifts, one extra bit catches the carry.
////////////////////////////////////////////////////////////

// Carry on top, result below.
logic [shift_pkg::DATA_W:0] lsl_wide;
// Result on top, carry below.
logic [shift_pkg::DATA_W:0] lsr_wide;
logic [shift_pkg::DATA_W:0] asr_wide;
logic [shift_pkg::DATA_W-1:0] ror_value;

assign lsl_wide  = {1'b0, i_source} << low_amount;
assign lsr_wide  = {i_source, 1'b0} >> low_amount;
assign asr_wide  = $signed({i_source, 1'b0}) >>> low_amount;
// Zero rotate folds back onto the source.
assign ror_value = (i_source >> low_amount) |
                   (i_source << (shift_pkg::DATA_W - low_amount));

////////////////////////////////////////////////////////////
// Mode select.
////////////////////////////////////////////////////////////

always_comb
begin
        // Pass through, carry untouched.
        o_result = i_source;
        o_carry  = i_carry_in;

        if (!i_disable)
        begin
                if (i_shift_op == shift_pkg::SH_RRX)
                begin
                        // Amount ignored.
                        o_result = {i_carry_in, i_source[shift_pkg::DATA_W-1:1]};
                        o_carry  = i_source[0];
                end
                else if (!amount_zero)
                begin
                        case (i_shift_op)
                        shift_pkg::SH_LSL:
                        begin
                                if (amount_below)
                                        {o_carry, o_result} = lsl_wide;
                                else
                                begin
                                        o_result = '0;
                                        o_carry  = amount_equal ? i_source[0] : 1'b0;
                                end
                        end
                        shift_pkg::SH_LSR:
                        begin
                                if (amount_below)
                                        {o_result, o_carry} = lsr_wide;
                                else
                                begin
                                        o_result = '0;
                                        o_carry  = amount_equal ?
                                                   i_source[shift_pkg::DATA_W-1] : 1'b0;
                                end
                        end
                        shift_pkg::SH_ASR:
                        begin
                                if (amount_below)
                                        {o_result, o_carry} = asr_wide;
                                else
                                begin
                                        // Sign fills everything.
                                        o_result = {shift_pkg::DATA_W{i_source[shift_pkg::DATA_W-1]}};
                                        o_carry  = i_source[shift_pkg::DATA_W-1];
                                end
                        end
                        shift_pkg::SH_ROR:
                        begin
                                o_result = ror_value;
                                // Multiple of 32 leaves source, carry is bit 31 either way.
                                o_carry  = ror_value[shift_pkg::DATA_W-1];
                        end
                        default:
                        begin
                                // Undefined code, leave as pass through.
                                o_result = i_source;
                        end
                        endcase
                end
        end
end

// Issue must never hand over a code outside the five modes.
a_shift_op_defined: assert property (@(posedge i_clk) disable iff (i_reset)
        i_shift_op inside {shift_pkg::SH_LSL, shift_pkg::SH_LSR, shift_pkg::SH_ASR,
                           shift_pkg::SH_ROR, shift_pkg::SH_RRX})
else $error("barrel_shifter: undefined shift opcode %0d", i_shift_op);

endmodule

/* verilog/operand_resolver.sv */
`timescale 1ns/1ps

module operand_resolver
(
        // Source descriptors and values read at issue.
        input  logic [shift_pkg::SRC_W-1:0]     i_alu_source,
        input  logic [shift_pkg::DATA_W-1:0]    i_alu_source_value,
        input  logic [shift_pkg::SRC_W-1:0]     i_shift_source,
        input  logic [shift_pkg::DATA_W-1:0]    i_shift_source_value,

        // Destination of the instruction held in this stage.
        input  logic [shift_pkg::REG_IDX_W-1:0] i_stage_destination_index,

        // ALU result of this cycle.
        input  logic [shift_pkg::DATA_W-1:0]    i_alu_value,
        input  logic                            i_alu_dav,

        // Resolved operands.
        output logic [shift_pkg::DATA_W-1:0]    o_alu_operand,
        output logic [shift_pkg::DATA_W-1:0]    o_shift_operand
);

////////////////////////////////////////////////////////////
// Forwarding rule, one definition for both operands.
////////////////////////////////////////////////////////////

function automatic logic [shift_pkg::DATA_W-1:0] resolve
(
        input logic [shift_pkg::SRC_W-1:0]     source,
        input logic [shift_pkg::DATA_W-1:0]    issue_value,
        input logic [shift_pkg::REG_IDX_W-1:0] stage_index,
        input logic [shift_pkg::DATA_W-1:0]    alu_value,
        input logic                            alu_dav
);
        logic [shift_pkg::REG_IDX_W-1:0] source_index;

        source_index = source[shift_pkg::REG_IDX_W-1:0];

        // Immediate payload wins outright.
        if (source[shift_pkg::IMMED_BIT])
                return source[shift_pkg::DATA_W-1:0];
        // Back to back dependency on the op in this stage.
        else if (source_index == stage_index && alu_dav)
                return alu_value;
        // No hazard, issue read is current.
        else
                return issue_value;
endfunction

// ALU source.
assign o_alu_operand = resolve(i_alu_source, i_alu_source_value,
                               i_stage_destination_index, i_alu_value, i_alu_dav);

// Shift source, always forwarded before the shifter.
assign o_shift_operand = resolve(i_shift_source, i_shift_source_value,
                                 i_stage_destination_index, i_alu_value, i_alu_dav);

// No X may escape while the ALU claims a valid result.
always_comb
begin
        if (i_alu_dav)
        begin
                a_no_unknown: assert final (!$isunknown({o_alu_operand, o_shift_operand}))
                else $error("operand_resolver: unknown operand with alu_dav high");
        end
end

endmodule

/* verilog/shift_pkg.sv */
package shift_pkg;

        ////////////////////////////////////////////////////////////
        // Datapath widths.
        ////////////////////////////////////////////////////////////

        // Width of one data word.
        localparam int DATA_W = 32;

        // Physical register index, 46 registers fit in six bits.
        localparam int REG_IDX_W = 6;

        // Source descriptor, immediate flag on top of the payload.
        localparam int SRC_W = DATA_W + 1;

        // Flag position, set means immediate.
        localparam int IMMED_BIT = 32;

        // Shift amount comes from the low byte of the length value.
        localparam int AMOUNT_W = 8;

        ////////////////////////////////////////////////////////////
        // Shift opcodes.
        ////////////////////////////////////////////////////////////

        // Five barrel shifter modes, codes 5 to 7 unused.
        typedef enum logic [2:0]
        {
                SH_LSL = 3'd0,
                SH_LSR = 3'd1,
                SH_ASR = 3'd2,
                SH_ROR = 3'd3,
                SH_RRX = 3'd4
        } shift_op_t;

endpackage

/* verilog/shift_stage_reg.sv */
`timescale 1ns/1ps

module shift_stage_reg
(
        input  logic                            i_clk,
        input  logic                            i_reset,

        // Clear outranks stall.
        input  logic                            i_clear,
        input  logic                            i_stall,

        // Next state of the stage.
        input  logic                            i_valid,
        input  logic [shift_pkg::DATA_W-1:0]    i_alu_operand,
        input  logic [shift_pkg::DATA_W-1:0]    i_shifted_value,
        input  logic                            i_shift_carry,
        input  logic [shift_pkg::REG_IDX_W-1:0] i_destination_index,

        // Registered stage contents.
        output logic                            o_valid,
        output logic [shift_pkg::DATA_W-1:0]    o_alu_source_value,
        output logic [shift_pkg::DATA_W-1:0]    o_shifted_value,
        output logic                            o_shift_carry,
        output logic [shift_pkg::REG_IDX_W-1:0] o_destination_index
);

// Normal advance, nothing holding or flushing.
logic load_en;

assign load_en = !i_reset && !i_clear && !i_stall;

////////////////////////////////////////////////////////////
// Control state.
////////////////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_valid             <= 1'b0;
                o_destination_index <= '0;
        end
        else if (i_clear)
        begin
                // Drop the op, keep the index for forwarding.
                o_valid <= 1'b0;
        end
        else if (!i_stall)
        begin
                o_valid             <= i_valid;
                o_destination_index <= i_destination_index;
        end
end

////////////////////////////////////////////////////////////
// Payload.
////////////////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (load_en)
        begin
                o_alu_source_value <= i_alu_operand;
                o_shifted_value    <= i_shifted_value;
                o_shift_carry      <= i_shift_carry;
        end
end

// A held stage shows the same op to the ALU on the next cycle.
// Payload is checked only once a valid op has been loaded.
a_stall_holds: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_stall && !i_clear) |=>
                $stable({o_valid, o_destination_index}) &&
                (!o_valid || $stable({o_alu_source_value, o_shifted_value, o_shift_carry})))
else $error("shift_stage_reg: output moved during stall");

endmodule

/* verilog/shift_stage_top.sv */
`timescale 1ns/1ps

module shift_stage_top
(
        input  logic                            i_clk,
        input  logic                            i_reset,

        // From issue.
        input  logic                            i_valid,
        input  logic [shift_pkg::SRC_W-1:0]     i_alu_source,
        input  logic [shift_pkg::DATA_W-1:0]    i_alu_source_value,
        input  logic [shift_pkg::SRC_W-1:0]     i_shift_source,
        input  logic [shift_pkg::DATA_W-1:0]    i_shift_source_value,
        input  logic [shift_pkg::DATA_W-1:0]    i_shift_length_value,
        input  shift_pkg::shift_op_t            i_shift_op,
        input  logic                            i_disable_shifter,
        input  logic [shift_pkg::REG_IDX_W-1:0] i_destination_index,
        input  logic                            i_carry_in,

        // From the ALU, same cycle.
        input  logic [shift_pkg::DATA_W-1:0]    i_alu_value,
        input  logic                            i_alu_dav,

        // Pipeline control.
        input  logic                            i_stall,
        input  logic                            i_clear,

        // To the ALU stage.
        output logic                            o_valid,
        output logic [shift_pkg::DATA_W-1:0]    o_alu_source_value,
        output logic [shift_pkg::DATA_W-1:0]    o_shifted_value,
        output logic                            o_shift_carry,
        output logic [shift_pkg::REG_IDX_W-1:0] o_destination_index
);

// Resolved operands.
logic [shift_pkg::DATA_W-1:0] alu_operand;
logic [shift_pkg::DATA_W-1:0] shift_operand;

// Shifter output.
logic [shift_pkg::DATA_W-1:0] shifted_value;
logic                         shift_carry;

////////////////////////////////////////////////////////////
// Forwarding, shifting, stage register.
////////////////////////////////////////////////////////////

// Registered destination loops back for hazard compare.
operand_resolver operand_resolver_inst
(
        .i_alu_source              (i_alu_source),
        .i_alu_source_value        (i_alu_source_value),
        .i_shift_source            (i_shift_source),
        .i_shift_source_value      (i_shift_source_value),
        .i_stage_destination_index (o_destination_index),
        .i_alu_value               (i_alu_value),
        .i_alu_dav                 (i_alu_dav),
        .o_alu_operand             (alu_operand),
        .o_shift_operand           (shift_operand)
);

// Amount is the low byte of the length value.
barrel_shifter barrel_shifter_inst
(
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_source   (shift_operand),
        .i_amount   (i_shift_length_value[shift_pkg::AMOUNT_W-1:0]),
        .i_shift_op (i_shift_op),
        .i_carry_in (i_carry_in),
        .i_disable  (i_disable_shifter),
        .o_result   (shifted_value),
        .o_carry    (shift_carry)
);

shift_stage_reg shift_stage_reg_inst
(
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_clear             (i_clear),
        .i_stall             (i_stall),
        .i_valid             (i_valid),
        .i_alu_operand       (alu_operand),
        .i_shifted_value     (shifted_value),
        .i_shift_carry       (shift_carry),
        .i_destination_index (i_destination_index),
        .o_valid             (o_valid),
        .o_alu_source_value  (o_alu_source_value),
        .o_shifted_value     (o_shifted_value),
        .o_shift_carry       (o_shift_carry),
        .o_destination_index (o_destination_index)
);

endmodule
